// File: build.f
hdl/dpPkg.sv
hdl/dispPkg.sv
hdl/fiboSeq.sv
hdl/hexSpeakSeq.sv
hdl/dpArbiter.sv
hdl/dataPath.sv
hdl/ssdDriver.sv
hdl/fiboAndHex.sv
verif/fiboAndHexTb.sv

// File: run.sh
#!/bin/sh
# compile and run the fiboAndHex testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
	--top-module fiboAndHexTb > build.log 2>&1 \
	|| { echo "compile failed, see build.log"; exit 1; }

./obj_dir/VfiboAndHexTb > sim.log 2>&1 \
	|| { echo "simulation aborted, see sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log \
	&& { echo "FAIL, see sim.log"; exit 1; } \
	|| { echo "PASS"; exit 0; }

// File: verif/fiboAndHexTb.sv
module fiboAndHexTb;
	import dpPkg::*;
	import dispPkg::*;

	localparam int clkPeriod = 10;
	localparam int fiboTerms = 24;
	localparam int scanDiv   = 4;
	// fibonacci gets every other slot, so two full runs per seed plus a few extra
	localparam int resultsPerSeed = 4 * (2 + 3 * fiboTerms) + 20;
	// two seeds with reset overhead, doubled for margin
	localparam int watchdogCycles = 2 * 2 * (resultsPerSeed + 8);

	// hexspeak words in issue order
	localparam word_t hexWords [8] = '{
		16'hBEEF, 16'hCAFE, 16'hFACE, 16'hDEAD,
		16'hC0DE, 16'hF00D, 16'hBABE, 16'hD00D
	};

	// one-cold select pattern for each digit
	localparam digitSel_t digitPattern [4] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

	logic clk;
	logic rstN;
	logic [3:0] seed;
	regAddr_t dispReg;
	segment_t seg7;
	digitSel_t digitSel;
	logic resultValid;
	owner_t resultOwner;
	word_t A;
	word_t B;
	word_t Z;
	flags_t flags;

	integer randSeed = 32'hc247;
	int errorCount = 0;
	int resultCount = 0;

	// reference model state
	word_t modelRegs [16];
	int fiboStep;
	int fiboTermIdx;
	int hexStep;
	int hexIdx;
	owner_t expOwner;

	fiboAndHex #(
		.fiboTerms(fiboTerms),
		.scanDiv(scanDiv)
	) fiboAndHex_inst (
		.clk, .rstN, .seed, .dispReg,
		.seg7, .digitSel, .resultValid, .resultOwner, .A, .B, .Z, .flags
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errorCount++;
			$display("ERR %s expected %0h actual %0h at %0t", name, expected, actual, $time);
		end
	endtask

	// back to the state right after reset
	task automatic resetModel();
		for (int i = 0; i < 16; i++) begin
			modelRegs[i] = '0;
		end
		fiboStep    = 0;
		fiboTermIdx = 0;
		hexStep     = 0;
		hexIdx      = 0;
		expOwner    = ownerFibo;
	endtask

	// flags worked out with integer arithmetic
	function automatic flags_t refFlags(input opcode_t op, input word_t a, input word_t b,
			input word_t z);
		int sum;
		int sgn;
		logic carry;
		logic ovf;
		carry = 1'b0;
		ovf   = 1'b0;
		if (op == opAdd) begin
			sum   = int'(a) + int'(b);
			sgn   = int'($signed(a)) + int'($signed(b));
			carry = (sum > 65535);
			ovf   = (sgn > 32767) || (sgn < -32768);
		end else if (op == opSub) begin
			// no borrow means carry
			carry = (a >= b);
			sgn   = int'($signed(a)) - int'($signed(b));
			ovf   = (sgn > 32767) || (sgn < -32768);
		end
		return {carry, z == 16'h0000, z[15], ovf, ($countones(z) % 2) == 0};
	endfunction

	//////////////////////////////////////////////////
	// reference model, one micro-op of one owner
	//////////////////////////////////////////////////
	function automatic word_t refNext(input owner_t who, output opcode_t op,
			output word_t a, output word_t b, output logic useA, output logic useB);
		word_t z;
		word_t word;
		int dst;
		op   = opMov;
		a    = '0;
		b    = '0;
		useA = 1'b0;
		useB = 1'b1;
		dst  = 0;
		if (who == ownerFibo) begin
			case (fiboStep)
				// r0 = 0
				0: dst = 0;
				// r1 = seed
				1: begin
					dst = 1;
					b   = word_t'(seed);
				end
				// r2 = r0 + r1
				2: begin
					op   = opAdd;
					dst  = 2;
					a    = modelRegs[0];
					b    = modelRegs[1];
					useA = 1'b1;
				end
				3: begin
					dst = 0;
					b   = modelRegs[1];
				end
				default: begin
					dst = 1;
					b   = modelRegs[2];
				end
			endcase
			z = (op == opAdd) ? word_t'(a + b) : b;
			if (fiboStep < 4) begin
				fiboStep++;
			end else if (fiboTermIdx == fiboTerms - 1) begin
				// run complete, reload the seed
				fiboStep    = 0;
				fiboTermIdx = 0;
			end else begin
				fiboStep = 2;
				fiboTermIdx++;
			end
		end else begin
			word = hexWords[hexIdx];
			dst  = 8;
			case (hexStep)
				0: begin
					b = word_t'(word[15:8]);
					z = b;
				end
				1: begin
					op   = opShl8;
					a    = modelRegs[8];
					useA = 1'b1;
					useB = 1'b0;
					z    = {a[7:0], 8'h00};
				end
				2: begin
					op   = opOr;
					a    = modelRegs[8];
					b    = word_t'(word[7:0]);
					useA = 1'b1;
					z    = a | b;
				end
				default: begin
					// finished word into r9
					dst = 9;
					b   = modelRegs[8];
					z   = word;
				end
			endcase
			if (hexStep < 3) begin
				hexStep++;
			end else begin
				hexStep = 0;
				hexIdx  = (hexIdx + 1) % 8;
			end
		end
		modelRegs[dst] = z;
		return z;
	endfunction

	//////////////////////////////////////////////////
	// comparison, sampled on the falling edge
	//////////////////////////////////////////////////
	initial begin : compareResults
		opcode_t expOp;
		word_t expA;
		word_t expB;
		word_t expZ;
		logic useA;
		logic useB;
		logic prevRstN;
		digitSel_t prevDigitSel;
		int scanCycle;
		int expDigit;
		prevRstN     = 1'b0;
		prevDigitSel = 4'b1110;
		scanCycle    = 0;
		resetModel();
		// first sample only after a real clock edge
		@(posedge clk);
		forever begin
			@(negedge clk);
			if (!prevRstN) begin
				// last edge saw reset low
				resetModel();
				scanCycle = 0;
				checkValue("resetValid", 0, resultValid);
				checkValue("resetZ", 0, Z);
				checkValue("resetA", 0, A);
				checkValue("resetB", 0, B);
				checkValue("resetFlags", 0, flags);
				checkValue("resetDigitSel", 4'b1110, digitSel);
			end else begin
				// select register lags the scan counter by one edge
				scanCycle++;
				expDigit = ((scanCycle - 1) / scanDiv) % 4;
				checkValue("digitSel", digitPattern[expDigit], digitSel);
				checkValue("resultValid", 1, resultValid);
				if (resultValid) begin
					// segments still show r9 from before this result
					if (digitSel == prevDigitSel) begin
						checkValue("seg7", hexToSeg(modelRegs[9][4*expDigit +: 4]), seg7);
					end
					checkValue("resultOwner", expOwner, resultOwner);
					expZ = refNext(expOwner, expOp, expA, expB, useA, useB);
					if (useA) checkValue("A", expA, A);
					if (useB) checkValue("B", expB, B);
					checkValue("Z", expZ, Z);
					checkValue("flags", refFlags(expOp, expA, expB, expZ), flags);
					// strict alternation under steady contention
					expOwner = ~expOwner;
					resultCount++;
				end
			end
			prevRstN     = rstN;
			prevDigitSel = digitSel;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial begin : stimulus
		integer seedVal;
		int target;
		rstN    = 1'b0;
		seed    = 4'd0;
		dispReg = 4'd9;
		for (int phase = 0; phase < 2; phase++) begin
			// new seed applied under reset
			@(posedge clk);
			seedVal = $random(randSeed);
			rstN <= 1'b0;
			seed <= seedVal[3:0];
			repeat (3) @(posedge clk);
			rstN <= 1'b1;
			target = resultCount + resultsPerSeed;
			while (resultCount < target) begin
				@(posedge clk);
			end
		end
		$display("checked %0d results, %0d errors", resultCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// results must keep arriving
	initial begin : watchdog
		#(watchdogCycles * clkPeriod);
		$display("timeout: only %0d results arrived before the time limit", resultCount);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: hdl/fiboAndHex.sv
module fiboAndHex #(
	parameter int fiboTerms = 24,
	parameter int scanDiv   = 4
) (
	input  logic                clk,
	input  logic                rstN,
	input  logic [3:0]          seed,
	input  dpPkg::regAddr_t     dispReg,
	output dispPkg::segment_t   seg7,
	output dispPkg::digitSel_t  digitSel,
	output logic                resultValid,
	output dpPkg::owner_t       resultOwner,
	output dpPkg::word_t        A,
	output dpPkg::word_t        B,
	output dpPkg::word_t        Z,
	output dpPkg::flags_t       flags
);
	import dpPkg::*;

	//////////////////////////////////////////////////
	// request sides
	//////////////////////////////////////////////////
	logic reqFibo, grantFibo, fiboSelectImm;
	opcode_t fiboOp;
	regAddr_t fiboDst, fiboReadRegA, fiboReadRegB;
	imm_t fiboImm;

	logic reqHex, grantHex, hexSelectImm;
	opcode_t hexOp;
	regAddr_t hexDst, hexReadRegA, hexReadRegB;
	imm_t hexImm;

	// winning micro-op into the datapath
	logic issue, selectImm;
	owner_t owner;
	opcode_t op;
	regAddr_t dst, readRegA, readRegB;
	imm_t imm;
	word_t dispValue;

	fiboSeq #(.fiboTerms(fiboTerms)) fiboSeq_inst (
		.clk, .rstN, .seed,
		.req(reqFibo), .op(fiboOp), .dst(fiboDst),
		.readRegA(fiboReadRegA), .readRegB(fiboReadRegB),
		.selectImm(fiboSelectImm), .imm(fiboImm), .grant(grantFibo)
	);

	hexSpeakSeq hexSpeakSeq_inst (
		.clk, .rstN,
		.req(reqHex), .op(hexOp), .dst(hexDst),
		.readRegA(hexReadRegA), .readRegB(hexReadRegB),
		.selectImm(hexSelectImm), .imm(hexImm), .grant(grantHex)
	);

	dpArbiter dpArbiter_inst (
		.clk, .rstN,
		.reqFibo, .fiboOp, .fiboDst, .fiboReadRegA, .fiboReadRegB, .fiboSelectImm, .fiboImm,
		.reqHex, .hexOp, .hexDst, .hexReadRegA, .hexReadRegB, .hexSelectImm, .hexImm,
		.grantFibo, .grantHex, .issue, .owner,
		.op, .dst, .readRegA, .readRegB, .selectImm, .imm
	);

	// shared register file, alu and flags
	dataPath dataPath_inst (
		.clk, .rstN, .issue, .owner, .op, .dst, .readRegA, .readRegB,
		.selectImm, .imm, .dispReg,
		.resultValid, .resultOwner, .A, .B, .Z, .flags, .dispValue
	);

	ssdDriver #(.scanDiv(scanDiv)) ssdDriver_inst (
		.clk, .rstN, .value(dispValue), .seg7, .digitSel
	);

endmodule

// File: hdl/ssdDriver.sv
module ssdDriver #(
	parameter int scanDiv = 4
) (
	input  logic                clk,
	input  logic                rstN,
	input  dpPkg::word_t        value,
	output dispPkg::segment_t   seg7,
	output dispPkg::digitSel_t  digitSel
);
	import dispPkg::*;

	// divider counts 0 .. scanDiv-1
	localparam int divW = (scanDiv > 1) ? $clog2(scanDiv) : 1;

	logic [divW-1:0] divCnt;
	logic [1:0] digitIdx;
	logic [3:0] nibble;

	// nibble k goes to digit k
	assign nibble = value[{digitIdx, 2'b00} +: 4];

	//////////////////////////////////////////////////
	// scan counter
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			divCnt   <= '0;
			digitIdx <= '0;
		end else if (divCnt == divW'(scanDiv - 1)) begin
			divCnt   <= '0;
			digitIdx <= digitIdx + 1'b1;
		end else begin
			divCnt <= divCnt + 1'b1;
		end
	end

	// segments and select registered together, so they stay aligned
	always_ff @(posedge clk) begin
		if (!rstN) begin
			seg7     <= '1;
			digitSel <= 4'b1110;
		end else begin
			seg7     <= hexToSeg(nibble);
			digitSel <= ~(4'b0001 << digitIdx);
		end
	end

	// exactly one digit driven low
	digitOneCold: assert property (@(posedge clk) disable iff (!rstN)
		$onehot(~digitSel))
		else $error("digitSel not one-cold");

endmodule

// File: hdl/dataPath.sv
module dataPath (
	input  logic              clk,
	input  logic              rstN,
	input  logic              issue,
	input  dpPkg::owner_t     owner,
	input  dpPkg::opcode_t    op,
	input  dpPkg::regAddr_t   dst,
	input  dpPkg::regAddr_t   readRegA,
	input  dpPkg::regAddr_t   readRegB,
	input  logic              selectImm,
	input  dpPkg::imm_t       imm,
	input  dpPkg::regAddr_t   dispReg,
	output logic              resultValid,
	output dpPkg::owner_t     resultOwner,
	output dpPkg::word_t      A,
	output dpPkg::word_t      B,
	output dpPkg::word_t      Z,
	output dpPkg::flags_t     flags,
	output dpPkg::word_t      dispValue
);
	import dpPkg::*;

	word_t regFile [16];

	// operands and alu result of the current issue
	word_t opA;
	word_t opB;
	word_t aluZ;
	logic [16:0] wideSum;
	logic aluCarry;
	logic aluOverflow;
	flags_t aluFlags;

	// immediate zero-extended onto port B
	assign opA = regFile[readRegA];
	assign opB = selectImm ? word_t'(imm) : regFile[readRegB];

	// display read port, no latency here
	assign dispValue = regFile[dispReg];

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////
	always_comb begin
		wideSum     = '0;
		aluZ        = '0;
		aluCarry    = 1'b0;
		aluOverflow = 1'b0;
		case (op)
			opAdd: begin
				wideSum     = {1'b0, opA} + {1'b0, opB};
				aluZ        = wideSum[15:0];
				aluCarry    = wideSum[16];
				// same-sign inputs, result sign flipped
				aluOverflow = (opA[15] == opB[15]) && (aluZ[15] != opA[15]);
			end
			opSub: begin
				// A + ~B + 1, carry high means no borrow
				wideSum     = {1'b0, opA} + {1'b0, ~opB} + 17'd1;
				aluZ        = wideSum[15:0];
				aluCarry    = wideSum[16];
				aluOverflow = (opA[15] != opB[15]) && (aluZ[15] != opA[15]);
			end
			opAnd:  aluZ = opA & opB;
			opOr:   aluZ = opA | opB;
			opXor:  aluZ = opA ^ opB;
			opShl8: aluZ = {opA[7:0], 8'h00};
			opMov:  aluZ = opB;
			default: aluZ = '0;
		endcase
	end

	// zero, negative, parity track Z for every op
	always_comb begin
		aluFlags               = '0;
		aluFlags[flagCarry]    = aluCarry;
		aluFlags[flagZero]     = (aluZ == '0);
		aluFlags[flagNegative] = aluZ[15];
		aluFlags[flagOverflow] = aluOverflow;
		// set on an even count of ones
		aluFlags[flagParity]   = ~^aluZ;
	end

	//////////////////////////////////////////////////
	// write-back and result registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regFile[i] <= '0;
			end
			resultValid <= 1'b0;
			resultOwner <= ownerFibo;
			A           <= '0;
			B           <= '0;
			Z           <= '0;
			flags       <= '0;
		end else begin
			// one cycle behind the grant
			resultValid <= issue;
			if (issue) begin
				regFile[dst] <= aluZ;
				resultOwner  <= owner;
				A            <= opA;
				B            <= opB;
				Z            <= aluZ;
				flags        <= aluFlags;
			end
		end
	end

endmodule

// File: hdl/dpArbiter.sv
module dpArbiter (
	input  logic              clk,
	input  logic              rstN,
	// fibonacci request side
	input  logic              reqFibo,
	input  dpPkg::opcode_t    fiboOp,
	input  dpPkg::regAddr_t   fiboDst,
	input  dpPkg::regAddr_t   fiboReadRegA,
	input  dpPkg::regAddr_t   fiboReadRegB,
	input  logic              fiboSelectImm,
	input  dpPkg::imm_t       fiboImm,
	// hexspeak request side
	input  logic              reqHex,
	input  dpPkg::opcode_t    hexOp,
	input  dpPkg::regAddr_t   hexDst,
	input  dpPkg::regAddr_t   hexReadRegA,
	input  dpPkg::regAddr_t   hexReadRegB,
	input  logic              hexSelectImm,
	input  dpPkg::imm_t       hexImm,
	// grants and the winning micro-op
	output logic              grantFibo,
	output logic              grantHex,
	output logic              issue,
	output dpPkg::owner_t     owner,
	output dpPkg::opcode_t    op,
	output dpPkg::regAddr_t   dst,
	output dpPkg::regAddr_t   readRegA,
	output dpPkg::regAddr_t   readRegB,
	output logic              selectImm,
	output dpPkg::imm_t       imm
);
	import dpPkg::*;

	// who won the previous issue cycle
	owner_t lastWinner;

	// on contention the one that lost last time goes first
	assign grantFibo = reqFibo && (!reqHex || lastWinner == ownerHex);
	assign grantHex  = reqHex && (!reqFibo || lastWinner == ownerFibo);
	assign issue     = grantFibo || grantHex;
	assign owner     = grantHex ? ownerHex : ownerFibo;

	// steer the winner's fields
	assign op        = grantHex ? hexOp : fiboOp;
	assign dst       = grantHex ? hexDst : fiboDst;
	assign readRegA  = grantHex ? hexReadRegA : fiboReadRegA;
	assign readRegB  = grantHex ? hexReadRegB : fiboReadRegB;
	assign selectImm = grantHex ? hexSelectImm : fiboSelectImm;
	assign imm       = grantHex ? hexImm : fiboImm;

	// hex counts as last so fibonacci wins the first cycle
	always_ff @(posedge clk) begin
		if (!rstN) begin
			lastWinner <= ownerHex;
		end else if (issue) begin
			lastWinner <= owner;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	grantExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(grantFibo && grantHex))
		else $error("both requesters granted");

	grantNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		(grantFibo |-> reqFibo) and (grantHex |-> reqHex))
		else $error("grant without request");

endmodule

// File: hdl/hexSpeakSeq.sv
module hexSpeakSeq (
	input  logic              clk,
	input  logic              rstN,
	output logic              req,
	output dpPkg::opcode_t    op,
	output dpPkg::regAddr_t   dst,
	output dpPkg::regAddr_t   readRegA,
	output dpPkg::regAddr_t   readRegB,
	output logic              selectImm,
	output dpPkg::imm_t       imm,
	input  logic              grant
);
	import dpPkg::*;

	// hexspeak owns r8..r11
	localparam regAddr_t regBuild  = 4'd8;
	localparam regAddr_t regResult = 4'd9;

	// words in issue order
	localparam word_t wordTable [8] = '{
		16'hBEEF, 16'hCAFE, 16'hFACE, 16'hDEAD,
		16'hC0DE, 16'hF00D, 16'hBABE, 16'hD00D
	};

	typedef enum logic [1:0] {
		stLoadHi,
		stShift,
		stOrLo,
		stCopy
	} hexState_t;

	hexState_t state;
	logic [2:0] wordIdx;
	word_t curWord;

	assign curWord = wordTable[wordIdx];

	// never idle, one op per state
	assign req = 1'b1;

	//////////////////////////////////////////////////
	// micro-op fields
	//////////////////////////////////////////////////
	always_comb begin
		op        = opMov;
		dst       = regBuild;
		readRegA  = regBuild;
		readRegB  = regBuild;
		selectImm = 1'b0;
		imm       = '0;
		case (state)
			// r8 = high byte
			stLoadHi: begin
				selectImm = 1'b1;
				imm       = curWord[15:8];
			end
			// r8 = r8 << 8
			stShift: begin
				op = opShl8;
			end
			// r8 = r8 | low byte
			stOrLo: begin
				op        = opOr;
				selectImm = 1'b1;
				imm       = curWord[7:0];
			end
			// r9 = r8, finished word
			default: begin
				dst = regResult;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state   <= stLoadHi;
			wordIdx <= '0;
		end else if (grant) begin
			case (state)
				stLoadHi: state <= stShift;
				stShift:  state <= stOrLo;
				stOrLo:   state <= stCopy;
				default: begin
					state <= stLoadHi;
					// 3-bit index wraps after D00D
					wordIdx <= wordIdx + 1'b1;
				end
			endcase
		end
	end

endmodule

// File: hdl/fiboSeq.sv
module fiboSeq #(
	parameter int fiboTerms = 24
) (
	input  logic              clk,
	input  logic              rstN,
	input  logic [3:0]        seed,
	output logic              req,
	output dpPkg::opcode_t    op,
	output dpPkg::regAddr_t   dst,
	output dpPkg::regAddr_t   readRegA,
	output dpPkg::regAddr_t   readRegB,
	output logic              selectImm,
	output dpPkg::imm_t       imm,
	input  logic              grant
);
	import dpPkg::*;

	// fibonacci owns r0..r3, r3 unused
	localparam regAddr_t regPrev = 4'd0;
	localparam regAddr_t regCurr = 4'd1;
	localparam regAddr_t regNext = 4'd2;

	// term counter wide enough for fiboTerms - 1
	localparam int termW = (fiboTerms > 2) ? $clog2(fiboTerms) : 1;

	typedef enum logic [2:0] {
		stLoadZero,
		stLoadSeed,
		stAdd,
		stMovPrev,
		stMovCurr
	} fiboState_t;

	fiboState_t state;
	logic [termW-1:0] termCnt;
	logic lastTerm;

	assign lastTerm = (termCnt == termW'(fiboTerms - 1));

	// every state carries a micro-op
	assign req = 1'b1;

	//////////////////////////////////////////////////
	// micro-op fields, decoded from the state
	//////////////////////////////////////////////////
	always_comb begin
		op        = opMov;
		dst       = regPrev;
		readRegA  = regPrev;
		readRegB  = regCurr;
		selectImm = 1'b0;
		imm       = '0;
		case (state)
			// r0 = 0
			stLoadZero: begin
				selectImm = 1'b1;
			end
			// r1 = seed
			stLoadSeed: begin
				dst       = regCurr;
				selectImm = 1'b1;
				imm       = imm_t'(seed);
			end
			// r2 = r0 + r1, the new term
			stAdd: begin
				op  = opAdd;
				dst = regNext;
			end
			// r0 = r1
			stMovPrev: begin
				dst = regPrev;
			end
			// r1 = r2
			default: begin
				dst      = regCurr;
				readRegB = regNext;
			end
		endcase
	end

	// advance only on the edge that executes the granted op
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state   <= stLoadZero;
			termCnt <= '0;
		end else if (grant) begin
			case (state)
				stLoadZero: state <= stLoadSeed;
				stLoadSeed: state <= stAdd;
				stAdd:      state <= stMovPrev;
				stMovPrev:  state <= stMovCurr;
				default: begin
					// run done, start over from the seed
					if (lastTerm) begin
						state   <= stLoadZero;
						termCnt <= '0;
					end else begin
						state   <= stAdd;
						termCnt <= termCnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: hdl/dispPkg.sv
package dispPkg;

	// segments a..g from bit 6 down to bit 0, low = lit
	typedef logic [6:0] segment_t;
	// one digit enable per position, low = selected
	typedef logic [3:0] digitSel_t;

	// standard hex glyphs, lower case b and d
	function automatic segment_t hexToSeg(input logic [3:0] nibble);
		segment_t pattern;
		case (nibble)
			4'h0: pattern = 7'h01;
			4'h1: pattern = 7'h4F;
			4'h2: pattern = 7'h12;
			4'h3: pattern = 7'h06;
			4'h4: pattern = 7'h4C;
			4'h5: pattern = 7'h24;
			4'h6: pattern = 7'h20;
			4'h7: pattern = 7'h0F;
			4'h8: pattern = 7'h00;
			4'h9: pattern = 7'h04;
			4'hA: pattern = 7'h08;
			4'hB: pattern = 7'h60;
			4'hC: pattern = 7'h31;
			4'hD: pattern = 7'h42;
			4'hE: pattern = 7'h30;
			default: pattern = 7'h38;
		endcase
		return pattern;
	endfunction

endpackage

// File: hdl/dpPkg.sv
package dpPkg;

	//////////////////////////////////////////////////
	// datapath widths
	//////////////////////////////////////////////////

	// one data word, also the register width
	typedef logic [15:0] word_t;
	// index into the sixteen-entry register file
	typedef logic [3:0] regAddr_t;
	// immediate byte, zero-extended by the datapath
	typedef logic [7:0] imm_t;
	// {carry, zero, negative, overflow, parity}
	typedef logic [4:0] flags_t;

	// flag bit positions inside flags_t
	localparam int flagCarry    = 4;
	localparam int flagZero     = 3;
	localparam int flagNegative = 2;
	localparam int flagOverflow = 1;
	localparam int flagParity   = 0;

	//////////////////////////////////////////////////
	// micro-op encoding
	//////////////////////////////////////////////////

	// shl8 shifts operand A, mov passes operand B
	typedef enum logic [2:0] {
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opShl8,
		opMov
	} opcode_t;

	// requester id seen by the arbiter and the result port
	typedef logic owner_t;
	localparam owner_t ownerFibo = 1'b0;
	localparam owner_t ownerHex  = 1'b1;

endpackage
